// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_issue_pipe
FLIST     ?= tb.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD) -f $(FLIST)

run: $(BIN)
	@./$(BIN) > $(LOG) 2>&1; rc=$$?; cat $(LOG); \
	if [ $$rc -ne 0 ] || grep -q "TB FAILED" $(LOG) || ! grep -q "TB PASSED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)

// File: source/hazard_detect.sv
`timescale 1ns/1ps

module hazard_detect (
    input  logic                          id_valid,
    input  logic [hazard_pkg::INST_W-1:0] id_inst,
    input  logic                          ex_valid,
    input  logic [hazard_pkg::INST_W-1:0] ex_inst,
    input  logic                          mem_valid,
    input  logic [hazard_pkg::INST_W-1:0] mem_inst,
    output hazard_pkg::fwd_sel_e          fwd_rs1,
    output hazard_pkg::fwd_sel_e          fwd_rs2,
    output logic                          stall
);

    hazard_pkg::opcode_e id_op;
    hazard_pkg::opcode_e ex_op;
    hazard_pkg::opcode_e mem_op;

    logic [hazard_pkg::REG_W-1:0] id_rs1;
    logic [hazard_pkg::REG_W-1:0] id_rs2;
    logic [hazard_pkg::REG_W-1:0] ex_rd;
    logic [hazard_pkg::REG_W-1:0] mem_rd;

    // qualified use flags
    logic rs1_used;
    logic rs2_used;
    logic ex_writes;
    logic mem_writes;

    // lui, auipc and jal take no rs1
    function automatic logic reads_rs1(input hazard_pkg::opcode_e op);
        case (op)
            hazard_pkg::OP_LUI, hazard_pkg::OP_AUIPC, hazard_pkg::OP_JAL: reads_rs1 = 1'b0;
            default: reads_rs1 = 1'b1;
        endcase
    endfunction

    // only r-type, store and branch read rs2
    function automatic logic reads_rs2(input hazard_pkg::opcode_e op);
        case (op)
            hazard_pkg::OP_REG, hazard_pkg::OP_STORE, hazard_pkg::OP_BRANCH: reads_rs2 = 1'b1;
            default: reads_rs2 = 1'b0;
        endcase
    endfunction

    // store and branch have no destination
    function automatic logic writes_rd(input hazard_pkg::opcode_e op);
        writes_rd = (op != hazard_pkg::OP_STORE) && (op != hazard_pkg::OP_BRANCH);
    endfunction

    // ex beats mem, mem beats register file
    function automatic hazard_pkg::fwd_sel_e pick_src(input logic ex_hit, input logic mem_hit);
        if (ex_hit) begin
            pick_src = hazard_pkg::FWD_EX;
        end else if (mem_hit) begin
            pick_src = hazard_pkg::FWD_MEM;
        end else begin
            pick_src = hazard_pkg::FWD_NONE;
        end
    endfunction

    // field extraction
    assign id_op  = hazard_pkg::opcode_e'(id_inst[hazard_pkg::OPC_W-1:0]);
    assign ex_op  = hazard_pkg::opcode_e'(ex_inst[hazard_pkg::OPC_W-1:0]);
    assign mem_op = hazard_pkg::opcode_e'(mem_inst[hazard_pkg::OPC_W-1:0]);
    assign id_rs1 = id_inst[hazard_pkg::RS1_LSB +: hazard_pkg::REG_W];
    assign id_rs2 = id_inst[hazard_pkg::RS2_LSB +: hazard_pkg::REG_W];
    assign ex_rd  = ex_inst[hazard_pkg::RD_LSB +: hazard_pkg::REG_W];
    assign mem_rd = mem_inst[hazard_pkg::RD_LSB +: hazard_pkg::REG_W];

    assign rs1_used = id_valid && reads_rs1(id_op);
    assign rs2_used = id_valid && reads_rs2(id_op);
    // x0 is hardwired, a write to it never produces a value
    assign ex_writes  = ex_valid && writes_rd(ex_op) && (ex_rd != '0);
    assign mem_writes = mem_valid && writes_rd(mem_op) && (mem_rd != '0);

    // each source checked on its own
    assign fwd_rs1 = pick_src(rs1_used && ex_writes && (ex_rd == id_rs1),
                              rs1_used && mem_writes && (mem_rd == id_rs1));
    assign fwd_rs2 = pick_src(rs2_used && ex_writes && (ex_rd == id_rs2),
                              rs2_used && mem_writes && (mem_rd == id_rs2));

    // load data is not ready until mem, so an ex hit on a load waits one step
    assign stall = (ex_op == hazard_pkg::OP_LOAD) &&
                   ((fwd_rs1 == hazard_pkg::FWD_EX) || (fwd_rs2 == hazard_pkg::FWD_EX));

endmodule

// File: source/hazard_pkg.sv
package hazard_pkg;

    // instruction word width
    localparam int INST_W = 32;

    // opcode field, bits [6:0] of every rv32i word
    localparam int OPC_W = 7;

    // register specifier width, x0..x31
    localparam int REG_W = 5;

    // register field low bits inside the instruction word
    localparam int RD_LSB  = 7;
    localparam int RS1_LSB = 15;
    localparam int RS2_LSB = 20;

    // input queue entries, also the sender's credits after reset
    localparam int QUEUE_DEPTH = 4;

    // credits held toward the execute unit after reset
    localparam int OUT_CREDITS = 2;

    // queue pointer and occupancy widths
    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    // credit counter must hold the larger of the two totals
    localparam int CREDIT_MAX = (QUEUE_DEPTH > OUT_CREDITS) ? QUEUE_DEPTH : OUT_CREDITS;
    localparam int CREDIT_W = $clog2(CREDIT_MAX + 1);

    // rv32i major opcodes
    typedef enum logic [OPC_W-1:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        // register-immediate alu group
        OP_IMM    = 7'b0010011,
        // register-register alu group
        OP_REG    = 7'b0110011
    } opcode_e;

    // operand source for one execute input
    typedef enum logic [1:0] {
        // value comes from the register file
        FWD_NONE = 2'd0,
        // bypass from the ex result
        FWD_EX   = 2'd1,
        // bypass from the mem result
        FWD_MEM  = 2'd2
    } fwd_sel_e;

endpackage

// File: source/inst_queue.sv
`timescale 1ns/1ps

module inst_queue (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          in_valid,
    input  logic [hazard_pkg::INST_W-1:0] in_inst,
    output logic                          in_credit,
    output logic                          q_valid,
    output logic [hazard_pkg::INST_W-1:0] q_inst,
    input  logic                          q_pop
);

    // entry storage
    logic [hazard_pkg::INST_W-1:0] mem [hazard_pkg::QUEUE_DEPTH];

    logic [hazard_pkg::PTR_W-1:0] wr_ptr;
    logic [hazard_pkg::PTR_W-1:0] rd_ptr;
    // current occupancy
    logic [hazard_pkg::CNT_W-1:0] count;

    logic pop;

    // head is visible whenever something is stored
    assign q_valid = (count != '0);
    assign q_inst  = mem[rd_ptr];

    // ignore a pop request against an empty queue
    assign pop = q_pop && q_valid;

    // circular increment for any depth
    function automatic logic [hazard_pkg::PTR_W-1:0] ptr_next(
        input logic [hazard_pkg::PTR_W-1:0] ptr
    );
        if (ptr == hazard_pkg::PTR_W'(hazard_pkg::QUEUE_DEPTH - 1)) begin
            ptr_next = '0;
        end else begin
            ptr_next = ptr + 1'b1;
        end
    endfunction

    // the sender spent a credit for each write
    always_ff @(posedge clk) begin
        if (in_valid) begin
            mem[wr_ptr] <= in_inst;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            in_credit <= 1'b0;
        end else begin
            if (in_valid) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            // push and pop together leave count unchanged
            case ({in_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // each pop returns one credit a cycle later
            in_credit <= pop;
        end
    end

endmodule

// File: source/issue_pipe_top.sv
`timescale 1ns/1ps

module issue_pipe_top (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          in_valid,
    input  logic [hazard_pkg::INST_W-1:0] in_inst,
    output logic                          in_credit,
    output logic                          out_valid,
    output logic [hazard_pkg::INST_W-1:0] out_inst,
    output hazard_pkg::fwd_sel_e          out_fwd_rs1,
    output hazard_pkg::fwd_sel_e          out_fwd_rs2,
    input  logic                          out_credit
);

    // queue head toward issue
    logic                          q_valid;
    logic [hazard_pkg::INST_W-1:0] q_inst;
    logic                          q_pop;

    // slot contents seen by the hazard unit
    logic                          id_valid;
    logic [hazard_pkg::INST_W-1:0] id_inst;
    logic                          ex_valid;
    logic [hazard_pkg::INST_W-1:0] ex_inst;
    logic                          mem_valid;
    logic [hazard_pkg::INST_W-1:0] mem_inst;

    // same-cycle hazard result
    hazard_pkg::fwd_sel_e fwd_rs1;
    hazard_pkg::fwd_sel_e fwd_rs2;
    logic                 stall;

    inst_queue u_queue (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_inst   (in_inst),
        .in_credit (in_credit),
        .q_valid   (q_valid),
        .q_inst    (q_inst),
        .q_pop     (q_pop)
    );

    issue_stage u_issue (
        .clk         (clk),
        .rst_n       (rst_n),
        .q_valid     (q_valid),
        .q_inst      (q_inst),
        .q_pop       (q_pop),
        .id_valid    (id_valid),
        .id_inst     (id_inst),
        .ex_valid    (ex_valid),
        .ex_inst     (ex_inst),
        .mem_valid   (mem_valid),
        .mem_inst    (mem_inst),
        .fwd_rs1     (fwd_rs1),
        .fwd_rs2     (fwd_rs2),
        .stall       (stall),
        .out_credit  (out_credit),
        .out_valid   (out_valid),
        .out_inst    (out_inst),
        .out_fwd_rs1 (out_fwd_rs1),
        .out_fwd_rs2 (out_fwd_rs2)
    );

    hazard_detect u_hazard (
        .id_valid  (id_valid),
        .id_inst   (id_inst),
        .ex_valid  (ex_valid),
        .ex_inst   (ex_inst),
        .mem_valid (mem_valid),
        .mem_inst  (mem_inst),
        .fwd_rs1   (fwd_rs1),
        .fwd_rs2   (fwd_rs2),
        .stall     (stall)
    );

endmodule

// File: source/issue_stage.sv
`timescale 1ns/1ps

module issue_stage (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          q_valid,
    input  logic [hazard_pkg::INST_W-1:0] q_inst,
    output logic                          q_pop,
    output logic                          id_valid,
    output logic [hazard_pkg::INST_W-1:0] id_inst,
    output logic                          ex_valid,
    output logic [hazard_pkg::INST_W-1:0] ex_inst,
    output logic                          mem_valid,
    output logic [hazard_pkg::INST_W-1:0] mem_inst,
    input  hazard_pkg::fwd_sel_e          fwd_rs1,
    input  hazard_pkg::fwd_sel_e          fwd_rs2,
    input  logic                          stall,
    input  logic                          out_credit,
    output logic                          out_valid,
    output logic [hazard_pkg::INST_W-1:0] out_inst,
    output hazard_pkg::fwd_sel_e          out_fwd_rs1,
    output hazard_pkg::fwd_sel_e          out_fwd_rs2
);

    // credits left toward the execute unit
    logic [hazard_pkg::CREDIT_W-1:0] credits;

    logic step;
    logic issue;
    logic id_load;

    // pipeline moves only with an id entry and a credit in hand
    assign step  = id_valid && (credits != '0);
    // a stalled step pushes a bubble instead of issuing
    assign issue = step && !stall;
    // refill id when empty or when it just issued
    assign id_load = q_valid && (!id_valid || issue);
    assign q_pop   = id_load;

    // slot valid bits
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_valid  <= 1'b0;
            ex_valid  <= 1'b0;
            mem_valid <= 1'b0;
        end else begin
            if (id_load) begin
                id_valid <= 1'b1;
            end else if (issue) begin
                id_valid <= 1'b0;
            end
            if (step) begin
                // bubble on stall
                ex_valid  <= !stall;
                mem_valid <= ex_valid;
            end
        end
    end

    // slot payload follows the same step rules
    always_ff @(posedge clk) begin
        if (id_load) begin
            id_inst <= q_inst;
        end
        if (issue) begin
            ex_inst <= id_inst;
        end
        if (step) begin
            mem_inst <= ex_inst;
        end
    end

    // output credit counter
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credits <= hazard_pkg::CREDIT_W'(hazard_pkg::OUT_CREDITS);
        end else begin
            case ({issue, out_credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= issue;
        end
    end

    // issued word tagged with the selects seen in its id cycle
    always_ff @(posedge clk) begin
        if (issue) begin
            out_inst    <= id_inst;
            out_fwd_rs1 <= fwd_rs1;
            out_fwd_rs2 <= fwd_rs2;
        end
    end

endmodule

// File: tb.f
source/hazard_pkg.sv
source/inst_queue.sv
source/hazard_detect.sv
source/issue_stage.sv
source/issue_pipe_top.sv
testbench/issue_pipe_chk.sv
testbench/tb_issue_pipe.sv

// File: testbench/issue_pipe_chk.sv
`timescale 1ns/1ps

module issue_pipe_chk (
    input logic                         clk,
    input logic                         rst_n,
    input logic                         in_credit,
    input logic                         out_valid,
    input logic                         out_credit,
    input logic [hazard_pkg::CNT_W-1:0] count
);

    // issued words not yet answered by a credit pulse
    logic [hazard_pkg::CREDIT_W-1:0] in_flight;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_flight <= '0;
        end else begin
            case ({out_valid, out_credit})
                2'b10:   in_flight <= in_flight + 1'b1;
                2'b01:   in_flight <= in_flight - 1'b1;
                default: in_flight <= in_flight;
            endcase
        end
    end

    // a new issue needs a free credit downstream
    a_issue_credit: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> (in_flight < hazard_pkg::CREDIT_W'(hazard_pkg::OUT_CREDITS)))
        else $error("out_valid without an output credit");

    // credit-obeying sender never overflows the queue
    a_queue_depth: assert property (@(posedge clk) disable iff (!rst_n)
        count <= hazard_pkg::CNT_W'(hazard_pkg::QUEUE_DEPTH))
        else $error("queue count above depth");

    // both pulse outputs quiet in reset
    a_reset_quiet: assert property (@(posedge clk)
        !rst_n |-> (!in_credit && !out_valid))
        else $error("in_credit or out_valid high during reset");

endmodule

// File: testbench/tb_issue_pipe.sv
`timescale 1ns/1ps

module tb_issue_pipe;

    localparam int RESET_CYCLES = 16;
    // output credits are withheld for this long in the back-pressure test
    localparam int HOLD_CYCLES  = 50;
    localparam int N_RANDOM     = 200;

    logic                          clk;
    logic                          rst_n;
    logic                          in_valid;
    logic [hazard_pkg::INST_W-1:0] in_inst;
    logic                          in_credit;
    logic                          out_valid;
    logic [hazard_pkg::INST_W-1:0] out_inst;
    hazard_pkg::fwd_sel_e          out_fwd_rs1;
    hazard_pkg::fwd_sel_e          out_fwd_rs2;
    logic                          out_credit;

    // words still waiting for a credit
    logic [hazard_pkg::INST_W-1:0] pending[$];
    // words accepted by the DUT in order
    logic [hazard_pkg::INST_W-1:0] sent[$];

    int   in_credits;
    int   owed;
    int   issued;
    int   returns;
    int   errors;
    int   stalls;
    int   cycles;
    int   limit;
    int   n_inst;
    logic hold;
    logic [31:0] gen_seed;
    logic [31:0] ret_seed;

    // reference copies of the ex and mem slots
    logic [hazard_pkg::INST_W-1:0] model_ex_inst;
    logic [hazard_pkg::INST_W-1:0] model_mem_inst;
    logic                          model_ex_valid;
    logic                          model_mem_valid;

    hazard_pkg::opcode_e ops [9] = '{hazard_pkg::OP_LUI, hazard_pkg::OP_AUIPC,
        hazard_pkg::OP_JAL, hazard_pkg::OP_JALR, hazard_pkg::OP_BRANCH, hazard_pkg::OP_LOAD,
        hazard_pkg::OP_STORE, hazard_pkg::OP_IMM, hazard_pkg::OP_REG};

    issue_pipe_top dut0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_inst     (in_inst),
        .in_credit   (in_credit),
        .out_valid   (out_valid),
        .out_inst    (out_inst),
        .out_fwd_rs1 (out_fwd_rs1),
        .out_fwd_rs2 (out_fwd_rs2),
        .out_credit  (out_credit)
    );

    bind issue_pipe_top issue_pipe_chk chk0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_credit (out_credit),
        .count      (u_queue.count)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] lcg(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic void add_inst(input hazard_pkg::opcode_e op, input int rd,
                                     input int rs1, input int rs2);
        logic [hazard_pkg::INST_W-1:0] w;
        // random funct and immediate bits around the fields under test
        gen_seed = lcg(gen_seed);
        w = gen_seed;
        w[hazard_pkg::OPC_W-1:0] = op;
        w[hazard_pkg::RD_LSB +: hazard_pkg::REG_W]  = rd[4:0];
        w[hazard_pkg::RS1_LSB +: hazard_pkg::REG_W] = rs1[4:0];
        w[hazard_pkg::RS2_LSB +: hazard_pkg::REG_W] = rs2[4:0];
        pending.push_back(w);
    endfunction

    // register read by a consumer
    // unused sources come back as x0
    function automatic logic [4:0] src_reg(input logic [31:0] inst, input logic second);
        hazard_pkg::opcode_e op;
        op = hazard_pkg::opcode_e'(inst[6:0]);
        if (!second) begin
            if (op == hazard_pkg::OP_LUI || op == hazard_pkg::OP_AUIPC ||
                op == hazard_pkg::OP_JAL) begin
                return 5'd0;
            end
            return inst[hazard_pkg::RS1_LSB +: 5];
        end
        if (op == hazard_pkg::OP_REG || op == hazard_pkg::OP_STORE ||
            op == hazard_pkg::OP_BRANCH) begin
            return inst[hazard_pkg::RS2_LSB +: 5];
        end
        return 5'd0;
    endfunction

    // register written by an older slot
    // x0 when the slot writes nothing
    function automatic logic [4:0] dest_reg(input logic valid, input logic [31:0] inst);
        hazard_pkg::opcode_e op;
        op = hazard_pkg::opcode_e'(inst[6:0]);
        if (!valid || op == hazard_pkg::OP_STORE || op == hazard_pkg::OP_BRANCH) begin
            return 5'd0;
        end
        return inst[hazard_pkg::RD_LSB +: 5];
    endfunction

    function automatic hazard_pkg::fwd_sel_e bypass_for(input logic [4:0] src,
                                                        input logic [4:0] ex_d,
                                                        input logic [4:0] mem_d);
        // ex is the younger producer so it wins
        if (src != 5'd0 && src == ex_d) begin
            return hazard_pkg::FWD_EX;
        end
        if (src != 5'd0 && src == mem_d) begin
            return hazard_pkg::FWD_MEM;
        end
        return hazard_pkg::FWD_NONE;
    endfunction

    // expected {rs1, rs2} selects for the next issued word
    // model slots advance by one issue
    function automatic logic [3:0] model_issue(input logic [hazard_pkg::INST_W-1:0] inst);
        logic [4:0] s1;
        logic [4:0] s2;
        logic [4:0] ex_d;
        logic [4:0] mem_d;
        hazard_pkg::fwd_sel_e sel1;
        hazard_pkg::fwd_sel_e sel2;
        s1 = src_reg(inst, 1'b0);
        s2 = src_reg(inst, 1'b1);
        ex_d = dest_reg(model_ex_valid, model_ex_inst);
        // load data shows up in mem only
        // one bubble moves the load there
        if (ex_d != 5'd0 && model_ex_inst[6:0] == hazard_pkg::OP_LOAD &&
            (s1 == ex_d || s2 == ex_d)) begin
            model_mem_inst  = model_ex_inst;
            model_mem_valid = 1'b1;
            model_ex_valid  = 1'b0;
            ex_d = 5'd0;
            stalls = stalls + 1;
        end
        mem_d = dest_reg(model_mem_valid, model_mem_inst);
        sel1 = bypass_for(s1, ex_d, mem_d);
        sel2 = bypass_for(s2, ex_d, mem_d);
        model_mem_inst  = model_ex_inst;
        model_mem_valid = model_ex_valid;
        model_ex_inst   = inst;
        model_ex_valid  = 1'b1;
        return {sel1, sel2};
    endfunction

    task automatic value_error(input string sig, input logic [31:0] got,
                               input logic [31:0] exp);
        $display("** Error %0t ns: %s = %h, expected %h", $time, sig, got, exp);
        errors = errors + 1;
    endtask

    // one credit spent per word sent
    // returned credits arrive on in_credit
    always @(posedge clk) begin : drive_inputs
        int avail;
        if (rst_n) begin
            avail = in_credits + (in_credit ? 1 : 0);
            if (in_credit) begin
                returns <= returns + 1;
            end
            if (pending.size() > 0 && avail > 0) begin
                in_valid <= 1'b1;
                in_inst  <= pending[0];
                sent.push_back(pending.pop_front());
                avail = avail - 1;
            end else begin
                in_valid <= 1'b0;
            end
            in_credits <= avail;
        end
    end

    // downstream model returns credits after random delays unless held
    always @(posedge clk) begin : return_credits
        int due;
        if (rst_n) begin
            due = owed + (out_valid ? 1 : 0);
            ret_seed = lcg(ret_seed);
            if (due > 0 && !hold && ret_seed[31:30] != 2'b00) begin
                out_credit <= 1'b1;
                due = due - 1;
            end else begin
                out_credit <= 1'b0;
            end
            owed <= due;
        end
    end

    always @(posedge clk) begin : compare_outputs
        logic [hazard_pkg::INST_W-1:0] exp_inst;
        logic [3:0] exp_fwd;
        if (rst_n && out_valid) begin
            if (sent.size() == 0) begin
                $display("issue at %0t ns with no instruction outstanding", $time);
                errors = errors + 1;
            end else begin
                exp_inst = sent.pop_front();
                exp_fwd = model_issue(exp_inst);
                if (out_inst !== exp_inst) begin
                    value_error("out_inst", out_inst, exp_inst);
                end
                if (out_fwd_rs1 !== exp_fwd[3:2]) begin
                    value_error("out_fwd_rs1", 32'(out_fwd_rs1), 32'(exp_fwd[3:2]));
                end
                if (out_fwd_rs2 !== exp_fwd[1:0]) begin
                    value_error("out_fwd_rs2", 32'(out_fwd_rs2), 32'(exp_fwd[1:0]));
                end
            end
            issued <= issued + 1;
        end
    end

    always @(posedge clk) begin : watchdog
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("timeout: run not finished after %0d cycles", limit);
            $display("issued %0d of %0d, stalls %0d, errors %0d", issued, n_inst, stalls,
                     errors);
            $display("TB FAILED");
            $finish;
        end
    end

    initial begin : main_sequence
        int snap_issued;
        int snap_returns;
        logic [31:0] r;
        rst_n = 1'b0;
        in_valid = 1'b0;
        in_inst = '0;
        out_credit = 1'b0;
        hold = 1'b0;
        in_credits = hazard_pkg::QUEUE_DEPTH;
        owed = 0;
        issued = 0;
        returns = 0;
        errors = 0;
        stalls = 0;
        cycles = 0;
        gen_seed = 32'h3edd;
        ret_seed = 32'h3edd;
        model_ex_inst = '0;
        model_mem_inst = '0;
        model_ex_valid = 1'b0;
        model_mem_valid = 1'b0;
        // independent words then ex on rs1 with mem on rs2
        add_inst(hazard_pkg::OP_REG, 1, 2, 3);
        add_inst(hazard_pkg::OP_IMM, 4, 5, 6);
        add_inst(hazard_pkg::OP_REG, 5, 4, 1);
        // ex and mem both write x5
        add_inst(hazard_pkg::OP_IMM, 5, 1, 0);
        add_inst(hazard_pkg::OP_REG, 6, 5, 5);
        // load-use pair
        add_inst(hazard_pkg::OP_LOAD, 7, 6, 0);
        add_inst(hazard_pkg::OP_REG, 8, 7, 7);
        // x0 destination then reads of x0
        add_inst(hazard_pkg::OP_IMM, 0, 8, 0);
        add_inst(hazard_pkg::OP_REG, 9, 0, 0);
        // store and branch as producers
        add_inst(hazard_pkg::OP_STORE, 9, 9, 9);
        add_inst(hazard_pkg::OP_BRANCH, 9, 9, 9);
        add_inst(hazard_pkg::OP_REG, 10, 9, 9);
        // consumers with no rs1
        // then imm and load with rs2 ignored
        add_inst(hazard_pkg::OP_LUI, 11, 10, 10);
        add_inst(hazard_pkg::OP_AUIPC, 12, 11, 11);
        add_inst(hazard_pkg::OP_JAL, 13, 12, 12);
        add_inst(hazard_pkg::OP_IMM, 14, 1, 13);
        add_inst(hazard_pkg::OP_LOAD, 15, 2, 14);
        add_inst(hazard_pkg::OP_JALR, 1, 15, 15);
        // few registers so hazards are frequent
        for (int i = 0; i < N_RANDOM; i++) begin
            gen_seed = lcg(gen_seed);
            r = gen_seed;
            add_inst(ops[int'(r[31:28]) % 9], int'(r[21:20]), int'(r[23:22]), int'(r[25:24]));
        end
        n_inst = pending.size();
        limit = 20 * n_inst + RESET_CYCLES + HOLD_CYCLES;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        // back-pressure window
        while (issued < 60) @(posedge clk);
        hold <= 1'b1;
        repeat (HOLD_CYCLES - 20) @(posedge clk);
        snap_issued = issued;
        snap_returns = returns;
        repeat (20) @(posedge clk);
        if (issued != snap_issued) begin
            $display("instructions kept issuing while output credits were withheld");
            errors = errors + 1;
        end
        if (returns != snap_returns || in_credits != 0) begin
            $display("input credits still flowing under back-pressure, sender holds %0d",
                     in_credits);
            errors = errors + 1;
        end
        hold <= 1'b0;

        while (issued < n_inst) @(posedge clk);
        repeat (10) @(posedge clk);
        if (issued != n_inst || sent.size() != 0) begin
            $display("issued %0d instructions, %0d sent", issued, n_inst);
            errors = errors + 1;
        end
        if (in_credits != hazard_pkg::QUEUE_DEPTH) begin
            $display("sender ended with %0d input credits", in_credits);
            errors = errors + 1;
        end
        $display("issued %0d of %0d, stalls %0d, errors %0d", issued, n_inst, stalls, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule
